//--- logic/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Data path and address width
`define RV_XLEN 32

// Register index width for 32 architectural registers
`define RV_REG_AW 5

// First fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

//--- logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

   // Major opcodes the core executes
   typedef enum logic [6:0] {
      OPC_OP     = 7'b0110011,
      OPC_OP_IMM = 7'b0010011,
      OPC_LUI    = 7'b0110111,
      OPC_BRANCH = 7'b1100011,
      OPC_JAL    = 7'b1101111
   } opcode_e;

   // Low bits follow funct3 and the top bit is instr[30]
   typedef enum logic [3:0] {
      ALU_ADD    = 4'b0000,
      ALU_SLL    = 4'b0001,
      ALU_SLT    = 4'b0010,
      ALU_SLTU   = 4'b0011,
      ALU_XOR    = 4'b0100,
      ALU_SRL    = 4'b0101,
      ALU_OR     = 4'b0110,
      ALU_AND    = 4'b0111,
      ALU_SUB    = 4'b1000,
      ALU_SRA    = 4'b1101,
      ALU_PASS_B = 4'b1111
   } alu_op_e;

   // Same values as the branch funct3 field
   typedef enum logic [2:0] {
      BR_EQ  = 3'b000,
      BR_NE  = 3'b001,
      BR_LT  = 3'b100,
      BR_GE  = 3'b101,
      BR_LTU = 3'b110,
      BR_GEU = 3'b111
   } branch_e;

endpackage

`default_nettype wire

//--- logic/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module rv_decoder (
   input  logic [`RV_XLEN-1:0]   instr,
   output logic [`RV_REG_AW-1:0] rs1,
   output logic [`RV_REG_AW-1:0] rs2,
   output logic [`RV_REG_AW-1:0] rd,
   output logic [`RV_XLEN-1:0]   imm,
   output rv_pkg::alu_op_e       alu_op,
   output logic                  use_imm,
   output logic                  is_branch,
   output logic                  is_jal,
   output rv_pkg::branch_e       branch_cond,
   output logic                  reg_write
);

   rv_pkg::opcode_e     opcode;
   logic [2:0]          funct3;
   logic [`RV_XLEN-1:0] imm_i;
   logic [`RV_XLEN-1:0] imm_b;
   logic [`RV_XLEN-1:0] imm_u;
   logic [`RV_XLEN-1:0] imm_j;

   assign opcode = rv_pkg::opcode_e'(instr[6:0]);
   assign funct3 = instr[14:12];
   assign rs1    = instr[19:15];
   assign rs2    = instr[24:20];
   assign rd     = instr[11:7];

   // Sign-extended immediate formats
   assign imm_i = {{20{instr[31]}}, instr[31:20]};
   assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign imm_u = {instr[31:12], 12'b0};
   assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

   assign branch_cond = rv_pkg::branch_e'(funct3);

   // Shared funct3 map for register and immediate forms
   function automatic rv_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
      case (f3)
         3'b000:  return alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
         3'b001:  return rv_pkg::ALU_SLL;
         3'b010:  return rv_pkg::ALU_SLT;
         3'b011:  return rv_pkg::ALU_SLTU;
         3'b100:  return rv_pkg::ALU_XOR;
         3'b101:  return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
         3'b110:  return rv_pkg::ALU_OR;
         default: return rv_pkg::ALU_AND;
      endcase
   endfunction

   always_comb begin
      alu_op    = rv_pkg::ALU_ADD;
      imm       = imm_i;
      use_imm   = 1'b0;
      is_branch = 1'b0;
      is_jal    = 1'b0;
      reg_write = 1'b0;
      case (opcode)
         rv_pkg::OPC_OP: begin
            alu_op    = arith_op(funct3, instr[30]);
            reg_write = 1'b1;
         end
         rv_pkg::OPC_OP_IMM: begin
            // Bit 30 only picks srai here because addi keeps it as immediate data
            alu_op    = arith_op(funct3, instr[30] && funct3 == 3'b101);
            use_imm   = 1'b1;
            reg_write = 1'b1;
         end
         rv_pkg::OPC_LUI: begin
            alu_op    = rv_pkg::ALU_PASS_B;
            imm       = imm_u;
            use_imm   = 1'b1;
            reg_write = 1'b1;
         end
         rv_pkg::OPC_BRANCH: begin
            imm       = imm_b;
            is_branch = 1'b1;
         end
         rv_pkg::OPC_JAL: begin
            imm       = imm_j;
            is_jal    = 1'b1;
            reg_write = 1'b1;
         end
         default: begin
            reg_write = 1'b0;
         end
      endcase
      // x0 writes are dropped here
      if (rd == '0) begin
         reg_write = 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- logic/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module rv_regfile (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [`RV_REG_AW-1:0] rs1,
   input  logic [`RV_REG_AW-1:0] rs2,
   input  logic [`RV_REG_AW-1:0] rd,
   input  logic                  we,
   input  logic [`RV_XLEN-1:0]   wdata,
   output logic [`RV_XLEN-1:0]   rdata1,
   output logic [`RV_XLEN-1:0]   rdata2
);

   // x0 has no storage
   logic [`RV_XLEN-1:0] regs [1:(1 << `RV_REG_AW)-1];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 1; i < (1 << `RV_REG_AW); i++) begin
            regs[i] <= '0;
         end
      end else if (we && rd != '0) begin
         regs[rd] <= wdata;
      end
   end

   // Write-through for the writeback stage
   assign rdata1 = (rs1 == '0)       ? '0    :
                   (we && rd == rs1) ? wdata : regs[rs1];
   assign rdata2 = (rs2 == '0)       ? '0    :
                   (we && rd == rs2) ? wdata : regs[rs2];

endmodule

`default_nettype wire

//--- logic/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module rv_alu (
   input  rv_pkg::alu_op_e     op,
   input  logic [`RV_XLEN-1:0] a,
   input  logic [`RV_XLEN-1:0] b,
   input  rv_pkg::branch_e     cond,
   output logic [`RV_XLEN-1:0] result,
   output logic                taken
);

   logic [4:0] shamt;
   logic       lt_s;
   logic       lt_u;
   logic       eq;

   assign shamt = b[4:0];
   assign lt_s  = $signed(a) < $signed(b);
   assign lt_u  = a < b;
   assign eq    = a == b;

   always_comb begin
      case (op)
         rv_pkg::ALU_ADD:    result = a + b;
         rv_pkg::ALU_SUB:    result = a - b;
         rv_pkg::ALU_SLL:    result = a << shamt;
         rv_pkg::ALU_SLT:    result = {{(`RV_XLEN-1){1'b0}}, lt_s};
         rv_pkg::ALU_SLTU:   result = {{(`RV_XLEN-1){1'b0}}, lt_u};
         rv_pkg::ALU_XOR:    result = a ^ b;
         rv_pkg::ALU_SRL:    result = a >> shamt;
         // Arithmetic shift keeps the sign
         rv_pkg::ALU_SRA:    result = $signed(a) >>> shamt;
         rv_pkg::ALU_OR:     result = a | b;
         rv_pkg::ALU_AND:    result = a & b;
         rv_pkg::ALU_PASS_B: result = b;
         default:            result = a + b;
      endcase
   end

   // Branch comparator
   always_comb begin
      case (cond)
         rv_pkg::BR_EQ:  taken = eq;
         rv_pkg::BR_NE:  taken = !eq;
         rv_pkg::BR_LT:  taken = lt_s;
         rv_pkg::BR_GE:  taken = !lt_s;
         rv_pkg::BR_LTU: taken = lt_u;
         rv_pkg::BR_GEU: taken = !lt_u;
         default:        taken = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

//--- logic/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module rv_execute (
   input  logic                  valid,
   input  logic [`RV_XLEN-1:0]   pc,
   input  logic [`RV_REG_AW-1:0] rs1,
   input  logic [`RV_REG_AW-1:0] rs2,
   input  logic [`RV_XLEN-1:0]   rdata1,
   input  logic [`RV_XLEN-1:0]   rdata2,
   input  logic [`RV_XLEN-1:0]   imm,
   input  rv_pkg::alu_op_e       alu_op,
   input  rv_pkg::branch_e       branch_cond,
   input  logic                  use_imm,
   input  logic                  is_branch,
   input  logic                  is_jal,
   input  logic                  wb_we,
   input  logic [`RV_REG_AW-1:0] wb_rd,
   input  logic [`RV_XLEN-1:0]   wb_data,
   output logic [`RV_XLEN-1:0]   result,
   output logic                  redirect,
   output logic [`RV_XLEN-1:0]   target
);

   logic                fwd_a;
   logic                fwd_b;
   logic [`RV_XLEN-1:0] op_a;
   logic [`RV_XLEN-1:0] op_b_reg;
   logic [`RV_XLEN-1:0] op_b;
   logic [`RV_XLEN-1:0] alu_result;
   logic                taken;

   // Bypass from the instruction one stage ahead
   assign fwd_a = wb_we && wb_rd != '0 && wb_rd == rs1;
   assign fwd_b = wb_we && wb_rd != '0 && wb_rd == rs2;

   assign op_a     = fwd_a ? wb_data : rdata1;
   assign op_b_reg = fwd_b ? wb_data : rdata2;
   // Branches always compare two registers
   assign op_b     = use_imm ? imm : op_b_reg;

   rv_alu u_rv_alu (
      .op     (alu_op),
      .a      (op_a),
      .b      (op_b),
      .cond   (branch_cond),
      .result (alu_result),
      .taken  (taken)
   );

   // JAL links the return address
   assign result = is_jal ? pc + `RV_XLEN'(4) : alu_result;

   // Branch and JAL both use pc-relative offsets
   assign target = pc + imm;

   assign redirect = valid && (is_jal || (is_branch && taken));

endmodule

`default_nettype wire

//--- logic/rv_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module rv_core (
   input  logic                  clk,
   input  logic                  rst_n,
   output logic [`RV_XLEN-1:0]   imem_addr,
   input  logic [`RV_XLEN-1:0]   imem_data,
   output logic                  wb_valid,
   output logic [`RV_REG_AW-1:0] wb_rd,
   output logic [`RV_XLEN-1:0]   wb_data
);

   // Fetch
   logic [`RV_XLEN-1:0]   pc;
   logic [`RV_XLEN-1:0]   next_pc;

   // Fetch-decode register
   logic [`RV_XLEN-1:0]   fd_instr;
   logic [`RV_XLEN-1:0]   fd_pc;

   // Decode
   logic [`RV_REG_AW-1:0] dec_rs1;
   logic [`RV_REG_AW-1:0] dec_rs2;
   logic [`RV_REG_AW-1:0] dec_rd;
   logic [`RV_XLEN-1:0]   dec_imm;
   rv_pkg::alu_op_e       dec_alu_op;
   rv_pkg::branch_e       dec_branch_cond;
   logic                  dec_use_imm;
   logic                  dec_is_branch;
   logic                  dec_is_jal;
   logic                  dec_reg_write;
   logic [`RV_XLEN-1:0]   rf_rdata1;
   logic [`RV_XLEN-1:0]   rf_rdata2;

   // Decode-execute register
   logic                  de_valid;
   logic [`RV_XLEN-1:0]   de_pc;
   logic [`RV_REG_AW-1:0] de_rs1;
   logic [`RV_REG_AW-1:0] de_rs2;
   logic [`RV_REG_AW-1:0] de_rd;
   logic [`RV_XLEN-1:0]   de_rdata1;
   logic [`RV_XLEN-1:0]   de_rdata2;
   logic [`RV_XLEN-1:0]   de_imm;
   rv_pkg::alu_op_e       de_alu_op;
   rv_pkg::branch_e       de_branch_cond;
   logic                  de_use_imm;
   logic                  de_is_branch;
   logic                  de_is_jal;
   logic                  de_reg_write;

   // Execute
   logic [`RV_XLEN-1:0]   ex_result;
   logic                  ex_redirect;
   logic [`RV_XLEN-1:0]   ex_target;

   // Execute-writeback register
   logic                  ew_we;
   logic [`RV_REG_AW-1:0] ew_rd;
   logic [`RV_XLEN-1:0]   ew_data;

   assign next_pc   = ex_redirect ? ex_target : pc + `RV_XLEN'(4);
   assign imem_addr = pc;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc <= `RV_RESET_PC;
      end else begin
         pc <= next_pc;
      end
   end

   // Squashed fetch becomes a NOP
   always_ff @(posedge clk) begin
      if (!rst_n || ex_redirect) begin
         fd_instr <= `RV_NOP;
      end else begin
         fd_instr <= imem_data;
      end
   end

   always_ff @(posedge clk) begin
      fd_pc <= pc;
   end

   rv_decoder u_rv_decoder (
      .instr       (fd_instr),
      .rs1         (dec_rs1),
      .rs2         (dec_rs2),
      .rd          (dec_rd),
      .imm         (dec_imm),
      .alu_op      (dec_alu_op),
      .use_imm     (dec_use_imm),
      .is_branch   (dec_is_branch),
      .is_jal      (dec_is_jal),
      .branch_cond (dec_branch_cond),
      .reg_write   (dec_reg_write)
   );

   rv_regfile u_rv_regfile (
      .clk    (clk),
      .rst_n  (rst_n),
      .rs1    (dec_rs1),
      .rs2    (dec_rs2),
      .rd     (ew_rd),
      .we     (ew_we),
      .wdata  (ew_data),
      .rdata1 (rf_rdata1),
      .rdata2 (rf_rdata2)
   );

   // Instruction in decode is dropped on redirect
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         de_valid <= 1'b0;
      end else begin
         de_valid <= !ex_redirect;
      end
   end

   always_ff @(posedge clk) begin
      de_pc          <= fd_pc;
      de_rs1         <= dec_rs1;
      de_rs2         <= dec_rs2;
      de_rd          <= dec_rd;
      de_rdata1      <= rf_rdata1;
      de_rdata2      <= rf_rdata2;
      de_imm         <= dec_imm;
      de_alu_op      <= dec_alu_op;
      de_branch_cond <= dec_branch_cond;
      de_use_imm     <= dec_use_imm;
      de_is_branch   <= dec_is_branch;
      de_is_jal      <= dec_is_jal;
      de_reg_write   <= dec_reg_write;
   end

   rv_execute u_rv_execute (
      .valid       (de_valid),
      .pc          (de_pc),
      .rs1         (de_rs1),
      .rs2         (de_rs2),
      .rdata1      (de_rdata1),
      .rdata2      (de_rdata2),
      .imm         (de_imm),
      .alu_op      (de_alu_op),
      .branch_cond (de_branch_cond),
      .use_imm     (de_use_imm),
      .is_branch   (de_is_branch),
      .is_jal      (de_is_jal),
      .wb_we       (ew_we),
      .wb_rd       (ew_rd),
      .wb_data     (ew_data),
      .result      (ex_result),
      .redirect    (ex_redirect),
      .target      (ex_target)
   );

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ew_we <= 1'b0;
      end else begin
         ew_we <= de_valid && de_reg_write;
      end
   end

   always_ff @(posedge clk) begin
      ew_rd   <= de_rd;
      ew_data <= ex_result;
   end

   // One retirement strobe per register write
   assign wb_valid = ew_we;
   assign wb_rd    = ew_rd;
   assign wb_data  = ew_data;

endmodule

`default_nettype wire

//--- test/rv_core_assert.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module rv_core_assert (
   input logic                  clk,
   input logic                  rst_n,
   input logic [`RV_XLEN-1:0]   imem_addr,
   input logic                  wb_valid,
   input logic [`RV_REG_AW-1:0] wb_rd
);

   // Quiet during reset and in the first cycle after it
   assert property (@(posedge clk) !rst_n |=> !wb_valid)
      else $error("wb_valid high during or right after reset");

   // x0 writes are dropped in decode
   assert property (@(posedge clk) disable iff (!rst_n) wb_valid |-> wb_rd != '0)
      else $error("writeback strobe for x0");

   assert property (@(posedge clk) disable iff (!rst_n) imem_addr[1:0] == 2'b00)
      else $error("fetch address not word-aligned");

endmodule

bind rv_core rv_core_assert u_rv_core_assert (
   .clk       (clk),
   .rst_n     (rst_n),
   .imem_addr (imem_addr),
   .wb_valid  (wb_valid),
   .wb_rd     (wb_rd)
);

`default_nettype wire

//--- test/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_defs.svh"

module rv_core_tb;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 10;
   localparam int QUIET_CYCLES = 8;
   localparam int IMEM_WORDS   = 256;
   localparam int TESTS_WORDS  = 1024;

   logic                  clk;
   logic                  rst_n;
   logic [`RV_XLEN-1:0]   imem_addr;
   logic [`RV_XLEN-1:0]   imem_data;
   logic                  wb_valid;
   logic [`RV_REG_AW-1:0] wb_rd;
   logic [`RV_XLEN-1:0]   wb_data;

   // Program memory and the raw contents of the tests file
   logic [31:0] imem [0:IMEM_WORDS-1];
   logic [31:0] tests_mem [0:TESTS_WORDS-1];

   // Expected writes of the running test in retirement order
   logic [4:0]  exp_rd_q [$];
   logic [31:0] exp_data_q [$];

   int error_count;
   int test_count;
   int fail_count;
   int watchdog_cycles;
   logic watchdog_armed;

   rv_core u_rv_core (
      .clk       (clk),
      .rst_n     (rst_n),
      .imem_addr (imem_addr),
      .imem_data (imem_data),
      .wb_valid  (wb_valid),
      .wb_rd     (wb_rd),
      .wb_data   (wb_data)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // Instruction word follows the fetch address shortly after the edge
   always @(posedge clk) begin
      #1;
      imem_data <= imem[imem_addr[9:2]];
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected) begin
         error_count++;
         $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, expected);
      end
   endtask

   // Writeback port sampled mid-cycle
   always @(negedge clk) begin
      if (rst_n === 1'b1 && wb_valid === 1'b1) begin
         if (exp_rd_q.size() > 0) begin
            check_value("wb_rd", {27'b0, wb_rd}, {27'b0, exp_rd_q[0]});
            check_value("wb_data", wb_data, exp_data_q[0]);
            void'(exp_rd_q.pop_front());
            void'(exp_data_q.pop_front());
         end else begin
            error_count++;
            $display("Unexpected register write at %0t ns: x%0d written with %h",
                     $time, wb_rd, wb_data);
         end
      end
   end

   // Copies one test into the memory model and the expectation queues
   task automatic load_test(input int base, output int prog_len, output int write_len);
      int idx;
      int start;
      prog_len  = tests_mem[base];
      write_len = tests_mem[base + 1];
      start     = (`RV_RESET_PC >> 2) % IMEM_WORDS;
      for (int i = 0; i < IMEM_WORDS; i++) begin
         imem[i] = `RV_NOP;
      end
      // Program placed at the reset address
      for (int i = 0; i < prog_len; i++) begin
         imem[(start + i) % IMEM_WORDS] = tests_mem[base + 2 + i];
      end
      exp_rd_q.delete();
      exp_data_q.delete();
      idx = base + 2 + prog_len;
      for (int w = 0; w < write_len; w++) begin
         exp_rd_q.push_back(tests_mem[idx][4:0]);
         exp_data_q.push_back(tests_mem[idx + 1]);
         idx = idx + 2;
      end
   endtask

   task automatic run_test(input int base, output int next_base);
      int prog_len;
      int write_len;
      int errors_before;
      errors_before = error_count;
      @(posedge clk);
      #1;
      rst_n = 1'b0;
      load_test(base, prog_len, write_len);
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;
      // First fetch comes from the reset address
      check_value("imem_addr", imem_addr, `RV_RESET_PC);
      while (exp_rd_q.size() > 0) begin
         @(posedge clk);
      end
      // Window in which any further write is an error
      repeat (QUIET_CYCLES) @(posedge clk);
      test_count++;
      if (error_count == errors_before) begin
         $display("Test %0d passed: %0d words, %0d writes", test_count, prog_len, write_len);
      end else begin
         fail_count++;
         $display("Test %0d failed with %0d errors", test_count, error_count - errors_before);
      end
      next_base = base + 2 + prog_len + 2 * write_len;
   endtask

   initial begin
      int base;
      int next_base;
      int budget;
      clk            = 1'b0;
      rst_n          = 1'b0;
      imem_data      = `RV_NOP;
      error_count    = 0;
      test_count     = 0;
      fail_count     = 0;
      watchdog_armed = 1'b0;
      for (int i = 0; i < TESTS_WORDS; i++) begin
         tests_mem[i] = '0;
      end
      for (int i = 0; i < IMEM_WORDS; i++) begin
         imem[i] = `RV_NOP;
      end
      $readmemh("test/rv_tests.txt", tests_mem);

      // Time allowance from the size of every test
      base   = 0;
      budget = 0;
      while (tests_mem[base] != 0) begin
         budget = budget + RESET_CYCLES + 1 + QUIET_CYCLES + 50
                  + 4 * (tests_mem[base] + tests_mem[base + 1]);
         base = base + 2 + tests_mem[base] + 2 * tests_mem[base + 1];
      end
      watchdog_cycles = budget + 10;
      watchdog_armed  = 1'b1;
      if (base == 0) begin
         error_count++;
         $display("The tests file holds no tests");
      end

      base = 0;
      while (tests_mem[base] != 0) begin
         run_test(base, next_base);
         base = next_base;
      end

      $display("Tests run: %0d, tests failed: %0d, errors: %0d",
               test_count, fail_count, error_count);
      if (error_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   // Watchdog
   initial begin
      wait (watchdog_armed === 1'b1);
      repeat (watchdog_cycles) @(posedge clk);
      $display("Timeout after %0d cycles: the expected register writes never all arrived",
               watchdog_cycles);
      $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

//--- test/rv_tests.txt
// Per test: program length, write count, program words, then rd and value per write
// A zero program length ends the file
// R-type: x1=-7 x2=5, add sub sll slt sltu xor srl sra or and
0000000D 0000000C
FF900093 00500113 002081B3 40208233 002092B3 0020A333 0020B3B3 0020C433
0020D4B3 4020D533 0020E5B3 0020F633 0000006F
01 FFFFFFF9 02 00000005 03 FFFFFFFE 04 FFFFFFF4 05 FFFFFF20 06 00000001
07 00000000 08 FFFFFFFC 09 07FFFFFF 0A FFFFFFFF 0B FFFFFFFD 0C 00000001
// I-type and LUI
0000000C 0000000B
800000B7 F9C00113 00411193 0040D213 4040D293 0FF14313 12306393 7F017413
FFF12493 FFF13513 00513593 0000006F
01 80000000 02 FFFFFF9C 03 FFFFF9C0 04 08000000 05 F8000000 06 FFFFFF63
07 00000123 08 00000790 09 00000001 0A 00000001 0B 00000000
// Forwarding, write-through and x0
00000007 00000005
00A00093 00108113 002081B3 00500013 00300233 000002B3 0000006F
01 0000000A 02 0000000B 03 00000015 04 00000015 05 00000000
// Branches: each condition taken then not taken, x31 writes must not appear
00000027 0000000E
FFF00093 00100113
00108663 00100F93 00100F93 00100193 00208463 00100213
00209663 00100F93 00100F93 00200193 00109463 00200213
0020C663 00100F93 00100F93 00300193 00114463 00300213
00115663 00100F93 00100F93 00400193 0020D463 00400213
00116663 00100F93 00100F93 00500193 0020E463 00500213
0020F663 00100F93 00100F93 00600193 00117463 00600213
0000006F
01 FFFFFFFF 02 00000001 03 00000001 04 00000001 03 00000002 04 00000002
03 00000003 04 00000003 03 00000004 04 00000004 03 00000005 04 00000005
03 00000006 04 00000006
// JAL links x5 and skips two words
00000007 00000004
00100093 00C002EF 00100F93 00100F93 00508113 002281B3 0000006F
01 00000001 05 00000008 02 00000006 03 0000000E
00000000 00000000

//--- vlog.f
+incdir+logic
logic/rv_pkg.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_execute.sv
logic/rv_core.sv
test/rv_core_assert.sv
test/rv_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
BUILD_DIR ?= obj_dir
SIM       ?= rv_core_sim
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(SIM)
	@out="$$(./$(BUILD_DIR)/$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf $(BUILD_DIR)
